/* logic/rover_params.svh */
// build-wide constants; command codes assume the kit nec remote and an exact 50 mhz clock
`ifndef ROVER_PARAMS_SVH
`define ROVER_PARAMS_SVH

// board oscillator
`define ROVER_CLK_HZ 50000000

// one nec unit is 562.5 us, i.e. 9/16000 s
// divide first so the product stays inside 32 bits
`define NEC_UNIT_CYCLES (`ROVER_CLK_HZ / 16000 * 9)

// remote key codes, command byte of the nec frame
// power key toggles idle and manual
`define CMD_POWER 8'h12
// motion keys
`define CMD_FWD   8'h1A
`define CMD_BACK  8'h1E
`define CMD_LEFT  8'h14
`define CMD_RIGHT 8'h18
// halt, stays in manual
`define CMD_STOP  8'h16
// hand steering over to the camera
`define CMD_AUTO  8'h0F

// fixed level for motion keys in manual mode
`define MANUAL_SPEED 2'd2

`endif

/* logic/ir_pkg.sv */
// infrared link types only; button codes follow the command list order of the params header
package ir_pkg;

  // raw nec frame, first received bit at bit 0
  // [7:0] address, [15:8] ~address, [23:16] command, [31:24] ~command
  typedef logic [31:0] ir_frame_t;

  // one command byte
  typedef logic [7:0] ir_cmd_t;

  // decoded key index, 0 is no key
  typedef logic [2:0] button_t;

  // key indices as shown on the display
  localparam button_t btn_none  = 3'd0;
  localparam button_t btn_power = 3'd1;
  localparam button_t btn_fwd   = 3'd2;
  localparam button_t btn_back  = 3'd3;
  localparam button_t btn_left  = 3'd4;
  localparam button_t btn_right = 3'd5;
  localparam button_t btn_stop  = 3'd6;
  localparam button_t btn_auto  = 3'd7;

endpackage

/* logic/drive_pkg.sv */
// drive control types; enum ordinals are what the display shows, so keep the order fixed
package drive_pkg;

  // run mode
  // idle ignores all keys except power
  typedef enum logic [1:0] {
    idle   = 2'd0,
    manual = 2'd1,
    auto   = 2'd2
  } mode_t;

  // motor command towards the h-bridge side
  typedef enum logic [2:0] {
    stop       = 3'd0,
    forward    = 3'd1,
    reverse    = 3'd2,
    turn_left  = 3'd3,
    turn_right = 3'd4
  } drive_state_t;

  // direction code from the colour classifier
  typedef logic [2:0] cam_dir_t;

  // codes 4 to 7 are treated like none
  localparam cam_dir_t cam_none   = 3'd0;
  localparam cam_dir_t cam_left   = 3'd1;
  localparam cam_dir_t cam_centre = 3'd2;
  localparam cam_dir_t cam_right  = 3'd3;

  // motor speed level, 0 is standstill
  typedef logic [1:0] speed_t;

endpackage

/* logic/ir_nec_receiver.sv */
// plain nec only; address byte is not compared, repeat codes are dropped and the input idles high
`timescale 1ns/1ps
`include "rover_params.svh"

module ir_nec_receiver #(
  parameter int unit_cycles = `NEC_UNIT_CYCLES
) (
  input  logic            clk_50,
  input  logic            rst_n,
  input  logic            irda_rxd,
  output ir_pkg::ir_cmd_t cmd,
  output logic            cmd_valid,
  output logic            led_toggle
);

  localparam int cw = $clog2(unit_cycles + 1);

  // segment limits in rounded units
  localparam logic [5:0] lead_min    = 6'd12;
  localparam logic [5:0] data_min    = 6'd6;
  localparam logic [5:0] bit_one_min = 6'd3;
  localparam logic [4:0] space_limit = 5'd12;

  typedef enum logic [2:0] {
    wait_lead,
    lead_space,
    bit_mark,
    bit_space,
    stop
  } rx_state_t;

  rx_state_t         state;
  logic              rxd_s1;
  logic              rxd_s2;
  logic              mark;
  logic              mark_d;
  logic              mark_start;
  logic              mark_end;
  logic [cw-1:0]     cycle_cnt;
  logic [4:0]        unit_cnt;
  logic [5:0]        seg_units;
  logic [4:0]        bit_cnt;
  ir_pkg::ir_frame_t frame;
  logic              mark_ok;
  logic              bit_ok;
  logic              cmd_ok;
  logic              accept;

  // two-flop synchroniser with a high idle level
  always_ff @(posedge clk_50 or negedge rst_n) begin
    if (!rst_n) begin
      rxd_s1 <= 1'b1;
      rxd_s2 <= 1'b1;
      mark_d <= 1'b0;
    end else begin
      rxd_s1 <= irda_rxd;
      rxd_s2 <= rxd_s1;
      mark_d <= mark;
    end
  end

  // burst on the line is low
  assign mark       = ~rxd_s2;
  assign mark_start = mark & ~mark_d;
  assign mark_end   = ~mark & mark_d;

  // length of the current level is restarted on every edge
  // unit count saturates so long idles do not wrap
  always_ff @(posedge clk_50 or negedge rst_n) begin
    if (!rst_n) begin
      cycle_cnt <= '0;
      unit_cnt  <= '0;
    end else if (mark_start || mark_end) begin
      cycle_cnt <= '0;
      unit_cnt  <= '0;
    end else if (cycle_cnt == cw'(unit_cycles - 1)) begin
      cycle_cnt <= '0;
      if (unit_cnt != 5'h1F)
        unit_cnt <= unit_cnt + 5'd1;
    end else begin
      cycle_cnt <= cycle_cnt + cw'(1);
    end
  end

  // finished segment rounded to whole units
  assign seg_units = {1'b0, unit_cnt} + 6'(cycle_cnt >= cw'(unit_cycles / 2));

  // marks last one unit and spaces one (zero) or three (one) units
  assign mark_ok = (seg_units >= 6'd1) && (seg_units <= 6'd2);
  assign bit_ok  = (seg_units >= 6'd1) && (seg_units <= 6'd4);

  // command byte against its complement
  assign cmd_ok = (frame[23:16] == ~frame[31:24]);
  assign accept = (state == stop) && mark_end && mark_ok && cmd_ok;

  always_ff @(posedge clk_50 or negedge rst_n) begin
    if (!rst_n) begin
      state      <= wait_lead;
      bit_cnt    <= '0;
      cmd_valid  <= 1'b0;
      led_toggle <= 1'b0;
    end else begin
      cmd_valid <= accept;
      if (accept)
        led_toggle <= ~led_toggle;
      case (state)
        wait_lead: begin
          if (mark_end && seg_units >= lead_min)
            state <= lead_space;
        end
        lead_space: begin
          // an 8 unit space starts data and a 4 unit repeat space drops the frame
          if (mark_start) begin
            bit_cnt <= '0;
            state   <= (seg_units >= data_min) ? bit_mark : wait_lead;
          end else if (!mark && unit_cnt >= space_limit) begin
            state <= wait_lead;
          end
        end
        bit_mark: begin
          if (mark_end)
            state <= mark_ok ? bit_space : wait_lead;
        end
        bit_space: begin
          if (mark_start) begin
            bit_cnt <= bit_cnt + 5'd1;
            if (!bit_ok)
              state <= wait_lead;
            else if (bit_cnt == 5'd31)
              state <= stop;
            else
              state <= bit_mark;
          end else if (!mark && unit_cnt >= space_limit) begin
            state <= wait_lead;
          end
        end
        stop: begin
          // frame is judged at the end of the closing burst
          if (mark_end)
            state <= wait_lead;
        end
        default: state <= wait_lead;
      endcase
    end
  end

  // lsb-first shift with the new bit entering at the top
  always_ff @(posedge clk_50) begin
    if (state == bit_space && mark_start && bit_ok)
      frame <= {seg_units >= bit_one_min, frame[31:1]};
    if (accept)
      cmd <= frame[23:16];
  end

endmodule

/* logic/mode_controller.sv */
// keys act only on the strobe cycle; in idle every key but power is ignored, button included
`timescale 1ns/1ps
`include "rover_params.svh"

module mode_controller (
  input  logic                    clk_50,
  input  logic                    rst_n,
  input  ir_pkg::ir_cmd_t         cmd,
  input  logic                    cmd_valid,
  input  drive_pkg::cam_dir_t     cam_dir,
  input  drive_pkg::speed_t       speed,
  output ir_pkg::button_t         button,
  output drive_pkg::mode_t        mode,
  output drive_pkg::drive_state_t drive_state,
  output drive_pkg::speed_t       motor_speed
);

  ir_pkg::button_t         cmd_button;
  drive_pkg::drive_state_t auto_drive;
  drive_pkg::speed_t       auto_speed;
  logic                    active;

  // remote code to key index, 0 for unknown codes
  always_comb begin
    case (cmd)
      `CMD_POWER: cmd_button = ir_pkg::btn_power;
      `CMD_FWD:   cmd_button = ir_pkg::btn_fwd;
      `CMD_BACK:  cmd_button = ir_pkg::btn_back;
      `CMD_LEFT:  cmd_button = ir_pkg::btn_left;
      `CMD_RIGHT: cmd_button = ir_pkg::btn_right;
      `CMD_STOP:  cmd_button = ir_pkg::btn_stop;
      `CMD_AUTO:  cmd_button = ir_pkg::btn_auto;
      default:    cmd_button = ir_pkg::btn_none;
    endcase
  end

  // camera steering
  always_comb begin
    case (cam_dir)
      drive_pkg::cam_left:   auto_drive = drive_pkg::turn_left;
      drive_pkg::cam_centre: auto_drive = drive_pkg::forward;
      drive_pkg::cam_right:  auto_drive = drive_pkg::turn_right;
      drive_pkg::cam_none:   auto_drive = drive_pkg::stop;
      default:               auto_drive = drive_pkg::stop;
    endcase
  end

  // no speed while standing
  assign auto_speed = (auto_drive == drive_pkg::stop) ? 2'd0 : speed;

  assign active = (mode != drive_pkg::idle);

  always_ff @(posedge clk_50 or negedge rst_n) begin
    if (!rst_n) begin
      button      <= ir_pkg::btn_none;
      mode        <= drive_pkg::idle;
      drive_state <= drive_pkg::stop;
      motor_speed <= 2'd0;
    end else if (cmd_valid && cmd_button == ir_pkg::btn_power) begin
      // power always lands on a standstill
      button      <= cmd_button;
      mode        <= active ? drive_pkg::idle : drive_pkg::manual;
      drive_state <= drive_pkg::stop;
      motor_speed <= 2'd0;
    end else if (cmd_valid && active && cmd_button != ir_pkg::btn_none) begin
      button <= cmd_button;
      case (cmd_button)
        ir_pkg::btn_fwd: begin
          mode        <= drive_pkg::manual;
          drive_state <= drive_pkg::forward;
          motor_speed <= `MANUAL_SPEED;
        end
        ir_pkg::btn_back: begin
          mode        <= drive_pkg::manual;
          drive_state <= drive_pkg::reverse;
          motor_speed <= `MANUAL_SPEED;
        end
        ir_pkg::btn_left: begin
          mode        <= drive_pkg::manual;
          drive_state <= drive_pkg::turn_left;
          motor_speed <= `MANUAL_SPEED;
        end
        ir_pkg::btn_right: begin
          mode        <= drive_pkg::manual;
          drive_state <= drive_pkg::turn_right;
          motor_speed <= `MANUAL_SPEED;
        end
        ir_pkg::btn_stop: begin
          mode        <= drive_pkg::manual;
          drive_state <= drive_pkg::stop;
          motor_speed <= 2'd0;
        end
        default: begin
          // auto key, take the camera view right away
          mode        <= drive_pkg::auto;
          drive_state <= auto_drive;
          motor_speed <= auto_speed;
        end
      endcase
    end else if (mode == drive_pkg::auto) begin
      // follow the camera every cycle
      drive_state <= auto_drive;
      motor_speed <= auto_speed;
    end
  end

endmodule

/* logic/seg_display.sv */
// four active-low digits, segment g in bit 6; values above 9 show as hex letters
`timescale 1ns/1ps

module seg_display (
  input  logic                    clk_50,
  input  logic                    rst_n,
  input  ir_pkg::button_t         button,
  input  drive_pkg::mode_t        mode,
  input  drive_pkg::drive_state_t drive_state,
  input  drive_pkg::speed_t       speed,
  output logic [6:0]              hex0,
  output logic [6:0]              hex1,
  output logic [6:0]              hex2,
  output logic [6:0]              hex3
);

  // nibble to gfedcba, lit segment is 0
  function automatic logic [6:0] seg7(input logic [3:0] v);
    case (v)
      4'h0:    seg7 = 7'b1000000;
      4'h1:    seg7 = 7'b1111001;
      4'h2:    seg7 = 7'b0100100;
      4'h3:    seg7 = 7'b0110000;
      4'h4:    seg7 = 7'b0011001;
      4'h5:    seg7 = 7'b0010010;
      4'h6:    seg7 = 7'b0000010;
      4'h7:    seg7 = 7'b1111000;
      4'h8:    seg7 = 7'b0000000;
      4'h9:    seg7 = 7'b0010000;
      4'hA:    seg7 = 7'b0001000;
      4'hB:    seg7 = 7'b0000011;
      4'hC:    seg7 = 7'b1000110;
      4'hD:    seg7 = 7'b0100001;
      4'hE:    seg7 = 7'b0000110;
      default: seg7 = 7'b0001110;
    endcase
  endfunction

  // all digits start on 0
  always_ff @(posedge clk_50 or negedge rst_n) begin
    if (!rst_n) begin
      hex0 <= 7'b1000000;
      hex1 <= 7'b1000000;
      hex2 <= 7'b1000000;
      hex3 <= 7'b1000000;
    end else begin
      hex0 <= seg7({1'b0, button});
      hex1 <= seg7({2'b00, mode});
      hex2 <= seg7({1'b0, drive_state});
      hex3 <= seg7({2'b00, speed});
    end
  end

endmodule

/* logic/rover_top.sv */
// camera, audio and pll live outside; cam_dir and speed must already be in the clk_50 domain
`timescale 1ns/1ps
`include "rover_params.svh"

module rover_top #(
  parameter int unit_cycles = `NEC_UNIT_CYCLES
) (
  input  logic                    clk_50,
  input  logic                    rst_n,
  input  logic                    irda_rxd,
  input  drive_pkg::cam_dir_t     cam_dir,
  input  drive_pkg::speed_t       speed,
  output logic [6:0]              hex0,
  output logic [6:0]              hex1,
  output logic [6:0]              hex2,
  output logic [6:0]              hex3,
  output logic                    led_toggle,
  output drive_pkg::mode_t        mode,
  output drive_pkg::drive_state_t drive_state,
  output drive_pkg::speed_t       motor_speed
);

  ir_pkg::ir_cmd_t cmd;
  logic            cmd_valid;
  ir_pkg::button_t button;

  // remote frames to command strobes
  ir_nec_receiver #(
    .unit_cycles(unit_cycles)
  ) u_ir_nec_receiver (
    .clk_50    (clk_50),
    .rst_n     (rst_n),
    .irda_rxd  (irda_rxd),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .led_toggle(led_toggle)
  );

  // mode and drive state
  mode_controller u_mode_controller (
    .clk_50     (clk_50),
    .rst_n      (rst_n),
    .cmd        (cmd),
    .cmd_valid  (cmd_valid),
    .cam_dir    (cam_dir),
    .speed      (speed),
    .button     (button),
    .mode       (mode),
    .drive_state(drive_state),
    .motor_speed(motor_speed)
  );

  // hex0 key, hex1 mode, hex2 drive, hex3 speed
  seg_display u_seg_display (
    .clk_50     (clk_50),
    .rst_n      (rst_n),
    .button     (button),
    .mode       (mode),
    .drive_state(drive_state),
    .speed      (motor_speed),
    .hex0       (hex0),
    .hex1       (hex1),
    .hex2       (hex2),
    .hex3       (hex3)
  );

endmodule

/* bench/rover_tb.sv */
// runs the top level with unit_cycles of 8, so one nec frame lasts at most about 125 us
`timescale 1ns/1ps
`include "rover_params.svh"

module rover_tb;

  localparam int clk_ns = 100;
  localparam int unit = 8;
  // longest frame in units is lead, lead space, 32 ones and stop burst
  localparam int frame_units = 16 + 8 + 32 * 4 + 1;
  // one frame plus receive bound and register settling
  localparam int frame_ns = (frame_units + 2) * unit * clk_ns + 6 * clk_ns;
  localparam int n_tests = 4;
  localparam int frames_per_test = 6;
  localparam int watchdog_ns = n_tests * frames_per_test * frame_ns + 200 * clk_ns;

  // active-low gfedcba patterns for digits 0 to 7
  localparam logic [6:0] seg_table [8] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78
  };

  logic                    clk_50;
  logic                    rst_n;
  logic                    irda_rxd;
  drive_pkg::cam_dir_t     cam_dir;
  drive_pkg::speed_t       speed;
  logic [6:0]              hex0;
  logic [6:0]              hex1;
  logic [6:0]              hex2;
  logic [6:0]              hex3;
  logic                    led_toggle;
  drive_pkg::mode_t        mode;
  drive_pkg::drive_state_t drive_state;
  drive_pkg::speed_t       motor_speed;

  int                      errors;
  integer                  seed;

  // expected outputs kept by the tests
  drive_pkg::mode_t        exp_mode;
  drive_pkg::drive_state_t exp_drive;
  drive_pkg::speed_t       exp_speed;
  ir_pkg::button_t         exp_btn;

  rover_top #(
    .unit_cycles(unit)
  ) uut (
    .clk_50     (clk_50),
    .rst_n      (rst_n),
    .irda_rxd   (irda_rxd),
    .cam_dir    (cam_dir),
    .speed      (speed),
    .hex0       (hex0),
    .hex1       (hex1),
    .hex2       (hex2),
    .hex3       (hex3),
    .led_toggle (led_toggle),
    .mode       (mode),
    .drive_state(drive_state),
    .motor_speed(motor_speed)
  );

  initial clk_50 = 1'b0;
  always #(clk_ns / 2) clk_50 = ~clk_50;

  function automatic logic [6:0] seg_for(input logic [2:0] v);
    return seg_table[v];
  endfunction

  // camera code to drive state
  function automatic drive_pkg::drive_state_t steer_for(input drive_pkg::cam_dir_t c);
    case (c)
      3'd1:    return drive_pkg::turn_left;
      3'd2:    return drive_pkg::forward;
      3'd3:    return drive_pkg::turn_right;
      default: return drive_pkg::stop;
    endcase
  endfunction

  function automatic bit known_code(input ir_pkg::ir_cmd_t c);
    return c == `CMD_POWER || c == `CMD_FWD || c == `CMD_BACK || c == `CMD_LEFT ||
           c == `CMD_RIGHT || c == `CMD_STOP || c == `CMD_AUTO;
  endfunction

  task automatic check_mode(input string name, input drive_pkg::mode_t exp,
                            input drive_pkg::mode_t act);
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: mode expected %s actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic check_drive(input string name, input drive_pkg::drive_state_t exp,
                             input drive_pkg::drive_state_t act);
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: drive expected %s actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic check_speed(input string name, input drive_pkg::speed_t exp,
                             input drive_pkg::speed_t act);
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: speed expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_hex(input string name, input logic [6:0] exp, input logic [6:0] act);
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: segments expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_led(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: led_toggle expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic set_expected(input drive_pkg::mode_t m, input drive_pkg::drive_state_t d,
                              input drive_pkg::speed_t s, input ir_pkg::button_t b);
    exp_mode  = m;
    exp_drive = d;
    exp_speed = s;
    exp_btn   = b;
  endtask

  // outputs and all four digits against the expected state
  task automatic compare_state(input string name);
    check_mode(name, exp_mode, mode);
    check_drive(name, exp_drive, drive_state);
    check_speed(name, exp_speed, motor_speed);
    check_hex({name, " hex0"}, seg_for(exp_btn), hex0);
    check_hex({name, " hex1"}, seg_for(3'(exp_mode)), hex1);
    check_hex({name, " hex2"}, seg_for(3'(exp_drive)), hex2);
    check_hex({name, " hex3"}, seg_for(3'(exp_speed)), hex3);
  endtask

  // line level for a whole number of nec units
  task automatic drive_level(input logic level, input int units);
    irda_rxd = level;
    repeat (units * unit) @(negedge clk_50);
  endtask

  task automatic send_nec(input ir_pkg::ir_cmd_t addr, input ir_pkg::ir_cmd_t code,
                          input bit corrupt);
    ir_pkg::ir_frame_t frame;
    ir_pkg::ir_cmd_t   flip;
    flip = 8'h00;
    if (corrupt) begin
      flip = 8'($random(seed));
      // at least one complement bit must be wrong
      if (flip == 8'h00)
        flip = 8'h01;
    end
    frame = {~code ^ flip, code, ~addr, addr};
    drive_level(1'b0, 16);
    drive_level(1'b1, 8);
    // lsb first with a three unit space for a one
    for (int i = 0; i < 32; i++) begin
      drive_level(1'b0, 1);
      drive_level(1'b1, frame[i] ? 3 : 1);
    end
    drive_level(1'b0, 1);
    irda_rxd = 1'b1;
  endtask

  // lead, short space and stop burst only
  task automatic send_repeat();
    drive_level(1'b0, 16);
    drive_level(1'b1, 4);
    drive_level(1'b0, 1);
    irda_rxd = 1'b1;
  endtask

  // led_toggle marks an accepted frame; bound is two units plus three clocks
  task automatic wait_frame(input string name, input bit expect_flip);
    logic led_start;
    int   n;
    led_start = led_toggle;
    n = 0;
    while (led_toggle == led_start && n < 2 * unit + 3) begin
      @(negedge clk_50);
      n++;
    end
    if (expect_flip && led_toggle == led_start) begin
      errors++;
      $display("%s: frame was not accepted within two units of the stop burst", name);
    end else if (!expect_flip && led_toggle != led_start) begin
      errors++;
      $display("%s: led_toggle flipped for a frame that should be dropped", name);
    end
    // let controller and display settle
    repeat (3) @(negedge clk_50);
  endtask

  task automatic press(input string name, input ir_pkg::ir_cmd_t code);
    send_nec(8'($random(seed)), code, 1'b0);
    wait_frame(name, 1'b1);
  endtask

  task automatic after_reset();
    compare_state("reset");
    check_led("reset", 1'b0, led_toggle);
  endtask

  task automatic manual_keys();
    press("power on", `CMD_POWER);
    set_expected(drive_pkg::manual, drive_pkg::stop, 2'd0, ir_pkg::btn_power);
    compare_state("power on");
    press("forward", `CMD_FWD);
    set_expected(drive_pkg::manual, drive_pkg::forward, `MANUAL_SPEED, ir_pkg::btn_fwd);
    compare_state("forward");
    press("left", `CMD_LEFT);
    set_expected(drive_pkg::manual, drive_pkg::turn_left, `MANUAL_SPEED, ir_pkg::btn_left);
    compare_state("left");
    press("stop", `CMD_STOP);
    set_expected(drive_pkg::manual, drive_pkg::stop, 2'd0, ir_pkg::btn_stop);
    compare_state("stop");
    press("power off", `CMD_POWER);
    set_expected(drive_pkg::idle, drive_pkg::stop, 2'd0, ir_pkg::btn_power);
    compare_state("power off");
    // idle ignores the key and keeps the key digit
    press("forward in idle", `CMD_FWD);
    compare_state("forward in idle");
  endtask

  task automatic camera_steering();
    cam_dir = 3'd2;
    speed   = 2'd3;
    press("auto power on", `CMD_POWER);
    set_expected(drive_pkg::manual, drive_pkg::stop, 2'd0, ir_pkg::btn_power);
    compare_state("auto power on");
    press("auto key", `CMD_AUTO);
    set_expected(drive_pkg::auto, drive_pkg::forward, 2'd3, ir_pkg::btn_auto);
    compare_state("auto key");
    // every camera code at each nonzero speed
    for (int s = 1; s < 4; s++) begin
      for (int c = 0; c < 8; c++) begin
        cam_dir = 3'(c);
        speed   = 2'(s);
        repeat (2) @(negedge clk_50);
        exp_drive = steer_for(cam_dir);
        // only left, centre and right move
        exp_speed = (c >= 1 && c <= 3) ? 2'(s) : 2'd0;
        compare_state($sformatf("auto cam %0d speed %0d", c, s));
      end
    end
  endtask

  task automatic dropped_frames();
    ir_pkg::ir_cmd_t unknown;
    cam_dir = 3'd1;
    speed   = 2'd1;
    repeat (2) @(negedge clk_50);
    set_expected(drive_pkg::auto, drive_pkg::turn_left, 2'd1, ir_pkg::btn_auto);
    compare_state("bad setup");
    // would switch to manual forward if taken
    send_nec(8'($random(seed)), `CMD_FWD, 1'b1);
    wait_frame("corrupt", 1'b0);
    compare_state("corrupt");
    send_repeat();
    wait_frame("repeat", 1'b0);
    compare_state("repeat");
    do
      unknown = 8'($random(seed));
    while (known_code(unknown));
    send_nec(8'($random(seed)), unknown, 1'b0);
    wait_frame("unknown", 1'b1);
    compare_state("unknown");
  endtask

  initial begin
    seed     = 97773;
    errors   = 0;
    rst_n    = 1'b0;
    irda_rxd = 1'b1;
    cam_dir  = 3'd0;
    speed    = 2'd0;
    set_expected(drive_pkg::idle, drive_pkg::stop, 2'd0, ir_pkg::btn_none);
    repeat (5) @(negedge clk_50);
    rst_n = 1'b1;
    @(negedge clk_50);
    after_reset();
    manual_keys();
    camera_steering();
    dropped_frames();
    $display("rover_tb finished with %0d errors", errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  // bound from the frame count of all tests
  initial begin
    #(watchdog_ns);
    $display("timeout: tests still running after %0d ns", watchdog_ns);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* list.f */
+incdir+logic
logic/ir_pkg.sv
logic/drive_pkg.sv
logic/ir_nec_receiver.sv
logic/mode_controller.sv
logic/seg_display.sv
logic/rover_top.sv
bench/rover_tb.sv

/* Makefile */
# Verilator build and run of the rover control testbench

VERILATOR ?= verilator
TOP       ?= rover_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --timescale $(TIMESCALE)
SOURCES   := $(wildcard logic/*.sv logic/*.svh bench/*.sv)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
